// ==== logic/cpuPkg.sv ====
package cpuPkg;

	////////////////////////////////////////////////////////////
	// Widths and sizes
	////////////////////////////////////////////////////////////
	localparam int dataWidth    = 32;
	localparam int addrWidth    = 8;
	localparam int regAddrWidth = 5;
	localparam int memDepth     = 256;

	// Primary opcodes
	localparam logic [5:0] opR     = 6'h00;
	localparam logic [5:0] opJ     = 6'h02;
	localparam logic [5:0] opBeq   = 6'h04;
	localparam logic [5:0] opBne   = 6'h05;
	localparam logic [5:0] opAddiu = 6'h09;
	localparam logic [5:0] opSlti  = 6'h0A;
	localparam logic [5:0] opAndi  = 6'h0C;
	localparam logic [5:0] opOri   = 6'h0D;
	localparam logic [5:0] opXori  = 6'h0E;
	localparam logic [5:0] opLui   = 6'h0F;
	localparam logic [5:0] opLw    = 6'h23;
	localparam logic [5:0] opSw    = 6'h2B;
	localparam logic [5:0] opHalt  = 6'h3F;

	// R-type function codes
	localparam logic [5:0] fnSll  = 6'h00;
	localparam logic [5:0] fnSrl  = 6'h02;
	localparam logic [5:0] fnSra  = 6'h03;
	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSubu = 6'h23;
	localparam logic [5:0] fnAnd  = 6'h24;
	localparam logic [5:0] fnOr   = 6'h25;
	localparam logic [5:0] fnXor  = 6'h26;
	localparam logic [5:0] fnNor  = 6'h27;
	localparam logic [5:0] fnSlt  = 6'h2A;

	////////////////////////////////////////////////////////////
	// Control and stage payloads
	////////////////////////////////////////////////////////////
	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluXor,
		aluNor, aluSlt, aluSll, aluSrl, aluSra
	} aluOpT;

	// Forward source for an operand
	typedef enum logic [1:0] {
		fwdReg = 2'd0,
		fwdWb  = 2'd1,
		fwdMem = 2'd2
	} fwdSelT;

	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic memWrite;
		logic aluSrc;
		logic aluShiftImm;
		logic regDst;
		logic loadImm;
		logic halt;
		aluOpT aluOp;
	} ctrlT;

	typedef struct packed {
		logic [dataWidth-1:0] instr;
		logic [addrWidth-1:0] pcNext;
	} ifIdT;

	typedef struct packed {
		ctrlT ctrl;
		logic [dataWidth-1:0] readData1;
		logic [dataWidth-1:0] readData2;
		logic [dataWidth-1:0] imm;
		logic [regAddrWidth-1:0] rs;
		logic [regAddrWidth-1:0] rt;
		logic [regAddrWidth-1:0] rd;
		logic [regAddrWidth-1:0] sa;
	} idExT;

	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic memWrite;
		logic halt;
		logic [regAddrWidth-1:0] writeReg;
		logic [dataWidth-1:0] aluOut;
		logic [dataWidth-1:0] storeData;
	} exMemT;

	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic halt;
		logic [regAddrWidth-1:0] writeReg;
		logic [dataWidth-1:0] aluOut;
		logic [dataWidth-1:0] loadData;
	} memWbT;

endpackage

// ==== logic/stageReg.sv ====
`timescale 1ns/1ps

module stageReg #(
	parameter type payloadT = logic
) (
	input  logic    clk,
	input  logic    arstN,
	input  logic    run,
	input  logic    hold,
	input  logic    clear,
	input  payloadT d,
	output payloadT q
);

	// All-zero payload is a bubble with every control bit low
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			q <= '0;
		end else if (run && !hold) begin
			if (clear) begin
				q <= '0;
			end else begin
				q <= d;
			end
		end
	end

endmodule

// ==== logic/fetchStage.sv ====
`timescale 1ns/1ps

module fetchStage (
	input  logic clk,
	input  logic arstN,
	input  logic run,
	input  logic stall,
	input  logic redirect,
	input  logic [cpuPkg::addrWidth-1:0] redirectTarget,
	input  logic [cpuPkg::addrWidth-1:0] imemAddr,
	input  logic imemWe,
	input  logic [cpuPkg::dataWidth-1:0] imemData,
	output logic [cpuPkg::dataWidth-1:0] instr,
	output logic [cpuPkg::addrWidth-1:0] pcNext
);

	logic [cpuPkg::addrWidth-1:0] pc;
	logic [cpuPkg::dataWidth-1:0] imem [cpuPkg::memDepth];

	// Program load port, used only while the core is parked
	always_ff @(posedge clk) begin
		if (imemWe) begin
			imem[imemAddr] <= imemData;
		end
	end

	assign instr  = imem[pc];
	assign pcNext = pc + 1'b1;

	// Redirect wins, stall covers hazards and the halt hold
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
		end else if (run) begin
			if (redirect) begin
				pc <= redirectTarget;
			end else if (!stall) begin
				pc <= pcNext;
			end
		end
	end

	loadWhileRunning: assert property (@(posedge clk) disable iff (!arstN) run |-> !imemWe);

endmodule

// ==== logic/decodeStage.sv ====
`timescale 1ns/1ps

module decodeStage (
	input  logic clk,
	input  logic arstN,
	input  logic [cpuPkg::dataWidth-1:0] instr,
	input  logic [cpuPkg::addrWidth-1:0] pcNext,
	input  logic wbRegWrite,
	input  logic [cpuPkg::regAddrWidth-1:0] wbReg,
	input  logic [cpuPkg::dataWidth-1:0] wbResult,
	input  logic [cpuPkg::dataWidth-1:0] memAluOut,
	input  logic fwdBrA,
	input  logic fwdBrB,
	input  logic stall,
	output cpuPkg::idExT decoded,
	output logic redirect,
	output logic haltSeen,
	output logic [cpuPkg::addrWidth-1:0] redirectTarget,
	output logic branchUse
);

	logic [5:0] opcode;
	logic [5:0] funct;
	logic [cpuPkg::regAddrWidth-1:0] rs;
	logic [cpuPkg::regAddrWidth-1:0] rt;
	logic [cpuPkg::dataWidth-1:0] regs [32];
	logic [cpuPkg::dataWidth-1:0] rd1;
	logic [cpuPkg::dataWidth-1:0] rd2;
	logic [cpuPkg::dataWidth-1:0] brA;
	logic [cpuPkg::dataWidth-1:0] brB;
	logic [cpuPkg::dataWidth-1:0] imm;
	cpuPkg::ctrlT ctrl;
	logic isBeq, isBne, isJump, isHalt, taken, haltReg;

	assign opcode = instr[31:26];
	assign funct  = instr[5:0];
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];

	////////////////////////////////////////////////////////////
	// Control decode
	////////////////////////////////////////////////////////////
	always_comb begin
		ctrl = '0;
		ctrl.memToReg = (opcode == cpuPkg::opLw);
		ctrl.loadImm  = (opcode == cpuPkg::opLui);
		ctrl.halt     = (opcode == cpuPkg::opHalt);
		case (opcode)
			cpuPkg::opR: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst   = 1'b1;
				ctrl.aluShiftImm = funct inside {cpuPkg::fnSll, cpuPkg::fnSrl, cpuPkg::fnSra};
				case (funct)
					cpuPkg::fnSll:  ctrl.aluOp = cpuPkg::aluSll;
					cpuPkg::fnSrl:  ctrl.aluOp = cpuPkg::aluSrl;
					cpuPkg::fnSra:  ctrl.aluOp = cpuPkg::aluSra;
					cpuPkg::fnAddu: ctrl.aluOp = cpuPkg::aluAdd;
					cpuPkg::fnSubu: ctrl.aluOp = cpuPkg::aluSub;
					cpuPkg::fnAnd:  ctrl.aluOp = cpuPkg::aluAnd;
					cpuPkg::fnOr:   ctrl.aluOp = cpuPkg::aluOr;
					cpuPkg::fnXor:  ctrl.aluOp = cpuPkg::aluXor;
					cpuPkg::fnNor:  ctrl.aluOp = cpuPkg::aluNor;
					cpuPkg::fnSlt:  ctrl.aluOp = cpuPkg::aluSlt;
					default:        ctrl.regWrite = 1'b0;
				endcase
			end
			cpuPkg::opAddiu, cpuPkg::opLw, cpuPkg::opSlti, cpuPkg::opAndi,
			cpuPkg::opOri, cpuPkg::opXori, cpuPkg::opLui: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc   = 1'b1;
			end
			cpuPkg::opSw: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc   = 1'b1;
			end
			default: ;
		endcase
		// Immediate ALU flavours
		case (opcode)
			cpuPkg::opSlti: ctrl.aluOp = cpuPkg::aluSlt;
			cpuPkg::opAndi: ctrl.aluOp = cpuPkg::aluAnd;
			cpuPkg::opOri:  ctrl.aluOp = cpuPkg::aluOr;
			cpuPkg::opXori: ctrl.aluOp = cpuPkg::aluXor;
			cpuPkg::opLui:  ctrl.aluOp = cpuPkg::aluSll;
			default: ;
		endcase
	end

	assign isBeq  = (opcode == cpuPkg::opBeq);
	assign isBne  = (opcode == cpuPkg::opBne);
	assign isJump = (opcode == cpuPkg::opJ);
	assign isHalt = (opcode == cpuPkg::opHalt);

	// Logic ops take the zero-extended immediate
	assign imm = (opcode inside {cpuPkg::opAndi, cpuPkg::opOri, cpuPkg::opXori}) ?
		{16'b0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

	////////////////////////////////////////////////////////////
	// Register file with write-through
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (wbRegWrite && wbReg != '0) begin
			regs[wbReg] <= wbResult;
		end
	end

	assign rd1 = (rs == '0) ? '0 : (wbRegWrite && wbReg == rs) ? wbResult : regs[rs];
	assign rd2 = (rt == '0) ? '0 : (wbRegWrite && wbReg == rt) ? wbResult : regs[rt];

	assign decoded = '{ctrl: ctrl, readData1: rd1, readData2: rd2, imm: imm,
		rs: rs, rt: rt, rd: instr[15:11], sa: instr[10:6]};

	// Branch resolves here, compare operands may come from memory stage
	assign brA       = fwdBrA ? memAluOut : rd1;
	assign brB       = fwdBrB ? memAluOut : rd2;
	assign taken     = (isBeq && brA == brB) || (isBne && brA != brB);
	assign branchUse = isBeq || isBne;
	assign redirect  = (taken || isJump) && !stall;
	assign redirectTarget = isJump ? instr[cpuPkg::addrWidth-1:0] :
		pcNext + imm[cpuPkg::addrWidth-1:0];

	// Sticky once HALT leaves decode
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			haltReg <= 1'b0;
		end else if (isHalt && !stall) begin
			haltReg <= 1'b1;
		end
	end

	assign haltSeen = haltReg || isHalt;

endmodule

// ==== logic/executeStage.sv ====
`timescale 1ns/1ps

module executeStage (
	input  cpuPkg::idExT   fromDecode,
	input  cpuPkg::fwdSelT fwdA,
	input  cpuPkg::fwdSelT fwdB,
	input  logic [cpuPkg::dataWidth-1:0] memAluOut,
	input  logic [cpuPkg::dataWidth-1:0] wbResult,
	output cpuPkg::exMemT  toMem
);

	logic [cpuPkg::dataWidth-1:0] srcA;
	logic [cpuPkg::dataWidth-1:0] srcB;
	logic [cpuPkg::dataWidth-1:0] op1;
	logic [cpuPkg::dataWidth-1:0] op2;
	logic [cpuPkg::dataWidth-1:0] aluOut;
	cpuPkg::ctrlT ctrl;

	assign ctrl = fromDecode.ctrl;

	// Forwarding muxes
	always_comb begin
		case (fwdA)
			cpuPkg::fwdMem: srcA = memAluOut;
			cpuPkg::fwdWb:  srcA = wbResult;
			default:        srcA = fromDecode.readData1;
		endcase
		case (fwdB)
			cpuPkg::fwdMem: srcB = memAluOut;
			cpuPkg::fwdWb:  srcB = wbResult;
			default:        srcB = fromDecode.readData2;
		endcase
	end

	// LUI is a shift of the immediate by 16
	assign op1 = ctrl.loadImm ? 32'd16 :
		ctrl.aluShiftImm ? {27'b0, fromDecode.sa} : srcA;
	assign op2 = ctrl.aluSrc ? fromDecode.imm : srcB;

	////////////////////////////////////////////////////////////
	// ALU
	////////////////////////////////////////////////////////////
	always_comb begin
		case (ctrl.aluOp)
			cpuPkg::aluSub: aluOut = op1 - op2;
			cpuPkg::aluAnd: aluOut = op1 & op2;
			cpuPkg::aluOr:  aluOut = op1 | op2;
			cpuPkg::aluXor: aluOut = op1 ^ op2;
			cpuPkg::aluNor: aluOut = ~(op1 | op2);
			cpuPkg::aluSlt: aluOut = {31'b0, $signed(op1) < $signed(op2)};
			// Shifts move op2 by the low bits of op1
			cpuPkg::aluSll: aluOut = op2 << op1[4:0];
			cpuPkg::aluSrl: aluOut = op2 >> op1[4:0];
			cpuPkg::aluSra: aluOut = $signed(op2) >>> op1[4:0];
			default:        aluOut = op1 + op2;
		endcase
	end

	assign toMem = '{regWrite: ctrl.regWrite, memToReg: ctrl.memToReg,
		memWrite: ctrl.memWrite, halt: ctrl.halt,
		writeReg: ctrl.regDst ? fromDecode.rd : fromDecode.rt,
		aluOut: aluOut, storeData: srcB};

	always_comb begin
		fwdCodeValid: assert final (fwdA != 2'd3 && fwdB != 2'd3);
	end

endmodule

// ==== logic/resultStage.sv ====
`timescale 1ns/1ps

module resultStage (
	input  logic clk,
	input  logic arstN,
	input  logic run,
	input  cpuPkg::exMemT fromExec,
	input  cpuPkg::memWbT fromMem,
	output cpuPkg::memWbT toWb,
	output logic wbRegWrite,
	output logic halted,
	output logic wbValid,
	output logic [cpuPkg::regAddrWidth-1:0] wbReg,
	output logic [cpuPkg::dataWidth-1:0] wbResult
);

	logic [cpuPkg::dataWidth-1:0] dmem [cpuPkg::memDepth];
	logic [cpuPkg::addrWidth-1:0] dAddr;
	logic haltFlag;

	////////////////////////////////////////////////////////////
	// Memory stage
	////////////////////////////////////////////////////////////
	assign dAddr = fromExec.aluOut[cpuPkg::addrWidth-1:0];

	always_ff @(posedge clk) begin
		if (run && fromExec.memWrite) begin
			dmem[dAddr] <= fromExec.storeData;
		end
	end

	assign toWb = '{regWrite: fromExec.regWrite, memToReg: fromExec.memToReg,
		halt: fromExec.halt, writeReg: fromExec.writeReg,
		aluOut: fromExec.aluOut, loadData: dmem[dAddr]};

	////////////////////////////////////////////////////////////
	// Writeback stage
	////////////////////////////////////////////////////////////
	assign wbRegWrite = fromMem.regWrite;
	assign wbReg      = fromMem.writeReg;
	assign wbResult   = fromMem.memToReg ? fromMem.loadData : fromMem.aluOut;
	// One pulse per write, the register holds while parked
	assign wbValid    = run && fromMem.regWrite && fromMem.writeReg != '0;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			haltFlag <= 1'b0;
		end else if (fromMem.halt) begin
			haltFlag <= 1'b1;
		end
	end

	assign halted = haltFlag || fromMem.halt;

	// Everything behind HALT was flushed in fetch
	noWriteAfterHalt: assert property (@(posedge clk) disable iff (!arstN) halted |-> !wbValid);

endmodule

// ==== logic/hazardUnit.sv ====
`timescale 1ns/1ps

module hazardUnit (
	input  logic [cpuPkg::regAddrWidth-1:0] idRs,
	input  logic [cpuPkg::regAddrWidth-1:0] idRt,
	input  logic [cpuPkg::regAddrWidth-1:0] exRs,
	input  logic [cpuPkg::regAddrWidth-1:0] exRt,
	input  logic [cpuPkg::regAddrWidth-1:0] exWriteReg,
	input  logic [cpuPkg::regAddrWidth-1:0] memWriteReg,
	input  logic [cpuPkg::regAddrWidth-1:0] wbWriteReg,
	input  logic branchUse,
	input  logic exRegWrite,
	input  logic exMemToReg,
	input  logic memRegWrite,
	input  logic memMemToReg,
	input  logic wbRegWrite,
	output logic stall,
	output logic fwdBrA,
	output logic fwdBrB,
	output cpuPkg::fwdSelT fwdA,
	output cpuPkg::fwdSelT fwdB
);

	logic idUsesEx, idUsesMem, loadUse, branchEx, branchMem;

	// Memory stage result is newer, so it wins over writeback
	assign fwdA = (exRs != '0 && memRegWrite && memWriteReg == exRs) ? cpuPkg::fwdMem :
		(exRs != '0 && wbRegWrite && wbWriteReg == exRs) ? cpuPkg::fwdWb : cpuPkg::fwdReg;
	assign fwdB = (exRt != '0 && memRegWrite && memWriteReg == exRt) ? cpuPkg::fwdMem :
		(exRt != '0 && wbRegWrite && wbWriteReg == exRt) ? cpuPkg::fwdWb : cpuPkg::fwdReg;

	assign fwdBrA = idRs != '0 && memRegWrite && memWriteReg == idRs;
	assign fwdBrB = idRt != '0 && memRegWrite && memWriteReg == idRt;

	assign idUsesEx  = exWriteReg != '0 && (exWriteReg == idRs || exWriteReg == idRt);
	assign idUsesMem = memWriteReg != '0 && (memWriteReg == idRs || memWriteReg == idRt);

	// Loaded value in execute is not ready for decode
	assign loadUse   = exMemToReg && exRt != '0 && (exRt == idRs || exRt == idRt);
	assign branchEx  = branchUse && exRegWrite && idUsesEx;
	assign branchMem = branchUse && memMemToReg && idUsesMem;
	assign stall     = loadUse || branchEx || branchMem;

	// Load stalls rely on every load writing its destination
	always_comb begin
		loadWritesReg: assert final ((!exMemToReg || exRegWrite) &&
			(!memMemToReg || memRegWrite));
	end

endmodule

// ==== logic/pipelineCore.sv ====
`timescale 1ns/1ps

module pipelineCore (
	input  logic clk,
	input  logic arstN,
	input  logic run,
	input  logic imemWe,
	input  logic [cpuPkg::addrWidth-1:0] imemAddr,
	input  logic [cpuPkg::dataWidth-1:0] imemData,
	output logic wbValid,
	output logic [cpuPkg::regAddrWidth-1:0] wbReg,
	output logic [cpuPkg::dataWidth-1:0] wbData,
	output logic halted
);

	logic [cpuPkg::dataWidth-1:0] fetchInstr;
	logic [cpuPkg::addrWidth-1:0] fetchPcNext;
	logic [cpuPkg::addrWidth-1:0] redirectTarget;
	logic stall, redirect, haltSeen, branchUse, wbRegWrite, fwdBrA, fwdBrB;
	cpuPkg::fwdSelT fwdA, fwdB;
	cpuPkg::ifIdT  ifId;
	cpuPkg::idExT  idExD, idEx;
	cpuPkg::exMemT exMemD, exMem;
	cpuPkg::memWbT memWbD, memWb;

	////////////////////////////////////////////////////////////
	// Stages and pipeline registers
	////////////////////////////////////////////////////////////
	fetchStage u_fetch (.clk, .arstN, .run, .stall(stall || haltSeen), .redirect,
		.redirectTarget, .imemAddr, .imemWe, .imemData,
		.instr(fetchInstr), .pcNext(fetchPcNext));

	stageReg #(.payloadT(cpuPkg::ifIdT)) u_ifId (.clk, .arstN, .run, .hold(stall),
		.clear(redirect || haltSeen),
		.d(cpuPkg::ifIdT'{instr: fetchInstr, pcNext: fetchPcNext}), .q(ifId));

	decodeStage u_decode (.clk, .arstN, .instr(ifId.instr), .pcNext(ifId.pcNext),
		.wbRegWrite, .wbReg, .wbResult(wbData), .memAluOut(exMem.aluOut),
		.fwdBrA, .fwdBrB, .stall, .decoded(idExD), .redirect, .haltSeen,
		.redirectTarget, .branchUse);

	// Stall leaves a bubble in execute
	stageReg #(.payloadT(cpuPkg::idExT)) u_idEx (.clk, .arstN, .run, .hold(1'b0),
		.clear(stall), .d(idExD), .q(idEx));

	executeStage u_execute (.fromDecode(idEx), .fwdA, .fwdB, .memAluOut(exMem.aluOut),
		.wbResult(wbData), .toMem(exMemD));

	stageReg #(.payloadT(cpuPkg::exMemT)) u_exMem (.clk, .arstN, .run, .hold(1'b0),
		.clear(1'b0), .d(exMemD), .q(exMem));

	resultStage u_result (.clk, .arstN, .run, .fromExec(exMem), .fromMem(memWb),
		.toWb(memWbD), .wbRegWrite, .halted, .wbValid, .wbReg, .wbResult(wbData));

	stageReg #(.payloadT(cpuPkg::memWbT)) u_memWb (.clk, .arstN, .run, .hold(1'b0),
		.clear(1'b0), .d(memWbD), .q(memWb));

	hazardUnit u_hazard (.idRs(ifId.instr[25:21]), .idRt(ifId.instr[20:16]),
		.exRs(idEx.rs), .exRt(idEx.rt), .exWriteReg(exMemD.writeReg),
		.memWriteReg(exMem.writeReg), .wbWriteReg(wbReg), .branchUse,
		.exRegWrite(idEx.ctrl.regWrite), .exMemToReg(idEx.ctrl.memToReg),
		.memRegWrite(exMem.regWrite), .memMemToReg(exMem.memToReg), .wbRegWrite,
		.stall, .fwdBrA, .fwdBrB, .fwdA, .fwdB);

endmodule

// ==== tests/isaModel.svh ====
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// In-order reference for prog[]
// Fills expReg and expData with every write to a nonzero register and
// returns the number of executed instructions, or 0 when HALT is never met
function automatic int runModel();
	logic [31:0] r [32];
	logic [31:0] mem [cpuPkg::memDepth];
	logic [31:0] ins, a, b, se, ze, ea, res;
	logic [7:0] pc;
	logic [4:0] dst;
	logic wr;
	int count;
	r = '{default: '0};
	mem = '{default: '0};
	pc = '0;
	count = 0;
	expReg.delete();
	expData.delete();
	while (count < 1000) begin
		ins = prog[pc];
		a = r[ins[25:21]];
		b = r[ins[20:16]];
		se = {{16{ins[15]}}, ins[15:0]};
		ze = {16'b0, ins[15:0]};
		ea = a + se;
		dst = ins[20:16];
		wr = 1'b1;
		res = '0;
		count++;
		pc = pc + 8'd1;
		case (ins[31:26])
			cpuPkg::opR: begin
				dst = ins[15:11];
				case (ins[5:0])
					cpuPkg::fnSll:  res = b << ins[10:6];
					cpuPkg::fnSrl:  res = b >> ins[10:6];
					cpuPkg::fnSra:  res = $signed(b) >>> ins[10:6];
					cpuPkg::fnAddu: res = a + b;
					cpuPkg::fnSubu: res = a - b;
					cpuPkg::fnAnd:  res = a & b;
					cpuPkg::fnOr:   res = a | b;
					cpuPkg::fnXor:  res = a ^ b;
					cpuPkg::fnNor:  res = ~(a | b);
					cpuPkg::fnSlt:  res = {31'b0, $signed(a) < $signed(b)};
					default:        wr = 1'b0;
				endcase
			end
			cpuPkg::opAddiu: res = a + se;
			cpuPkg::opSlti:  res = {31'b0, $signed(a) < $signed(se)};
			cpuPkg::opAndi:  res = a & ze;
			cpuPkg::opOri:   res = a | ze;
			cpuPkg::opXori:  res = a ^ ze;
			cpuPkg::opLui:   res = {ins[15:0], 16'b0};
			cpuPkg::opLw:    res = mem[ea[7:0]];
			cpuPkg::opSw: begin
				mem[ea[7:0]] = b;
				wr = 1'b0;
			end
			cpuPkg::opBeq, cpuPkg::opBne: begin
				// Offset counts from the word after the branch
				if ((a == b) == (ins[31:26] == cpuPkg::opBeq)) begin
					pc = pc + se[7:0];
				end
				wr = 1'b0;
			end
			cpuPkg::opJ: begin
				pc = ins[7:0];
				wr = 1'b0;
			end
			cpuPkg::opHalt: return count;
			default: wr = 1'b0;
		endcase
		if (wr && dst != 5'd0) begin
			r[dst] = res;
			expReg.push_back(dst);
			expData.push_back(res);
		end
	end
	return 0;
endfunction

`endif

// ==== tests/coreTb.sv ====
`timescale 1ns/1ps

module coreTb;

	logic clk = 1'b0;
	logic arstN, run, imemWe;
	logic [cpuPkg::addrWidth-1:0] imemAddr;
	logic [cpuPkg::dataWidth-1:0] imemData;
	logic wbValid, halted;
	logic [cpuPkg::regAddrWidth-1:0] wbReg;
	logic [cpuPkg::dataWidth-1:0] wbData;

	logic [31:0] prog [cpuPkg::memDepth];
	logic [4:0] expReg [$];
	logic [31:0] expData [$];
	int progLen;
	int wbIdx;
	integer seed;

	`include "isaModel.svh"

	pipelineCore u_dut (.clk, .arstN, .run, .imemWe, .imemAddr, .imemData,
		.wbValid, .wbReg, .wbData, .halted);

	always #4 clk = ~clk;

	////////////////////////////////////////////////////////////
	// Instruction encoding
	////////////////////////////////////////////////////////////
	function automatic logic [31:0] regOp(input logic [5:0] fn, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] sa);
		return {cpuPkg::opR, rs, rt, rd, sa, fn};
	endfunction

	function automatic logic [31:0] immOp(input logic [5:0] op, input logic [4:0] rt,
		input logic [4:0] rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic emit(input logic [31:0] word);
		prog[progLen] = word;
		progLen++;
	endtask

	////////////////////////////////////////////////////////////
	// Checking
	////////////////////////////////////////////////////////////
	task automatic failRun();
		$display("TEST FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
			failRun();
		end
	endtask

	// Compare each writeback with the next model entry
	always @(negedge clk) begin
		if (!arstN) begin
			wbIdx = 0;
		end else if (wbValid) begin
			if (wbIdx >= expReg.size()) begin
				$display("Extra write to r%0d at %0t ns, the model has no more writes",
					wbReg, $time);
				failRun();
			end else begin
				checkValue({27'b0, wbReg}, {27'b0, expReg[wbIdx]}, "wbReg");
				checkValue(wbData, expData[wbIdx], "wbData");
				wbIdx++;
			end
		end
	end

	// Reset, load with run low, then run until halted
	task automatic runProgram(input string name);
		int count;
		int cycles;
		@(posedge clk);
		run <= 1'b0;
		arstN <= 1'b0;
		repeat (3) @(posedge clk);
		checkValue({31'b0, halted}, 32'd0, "halted after reset");
		arstN <= 1'b1;
		count = runModel();
		if (count == 0) begin
			$display("Reference model of %s never reached HALT", name);
			failRun();
		end
		for (int i = 0; i < progLen; i++) begin
			@(posedge clk);
			imemWe <= 1'b1;
			imemAddr <= i[7:0];
			imemData <= prog[i];
		end
		@(posedge clk);
		imemWe <= 1'b0;
		run <= 1'b1;
		cycles = 0;
		while (halted !== 1'b1) begin
			@(negedge clk);
			cycles++;
			if (cycles > 4 * count + 50) begin
				$display("Timeout in %s, no HALT after %0d cycles", name, cycles);
				failRun();
			end
		end
		if (wbIdx != expReg.size()) begin
			$display("Missing writes in %s, saw %0d of %0d", name, wbIdx, expReg.size());
			failRun();
		end
		// No write back after HALT and halted stays high
		repeat (5) begin
			@(negedge clk);
			checkValue({31'b0, halted}, 32'd1, "halted");
		end
		$display("%s: %0d writes in %0d cycles", name, wbIdx, cycles);
	endtask

	////////////////////////////////////////////////////////////
	// Programs
	////////////////////////////////////////////////////////////
	task automatic buildAluProgram();
		progLen = 0;
		emit(immOp(cpuPkg::opAddiu, 5'd1, 5'd0, 16'h1234));
		emit(immOp(cpuPkg::opAddiu, 5'd2, 5'd0, 16'hFFFB));
		// Back-to-back chain with operands from memory and writeback
		emit(regOp(cpuPkg::fnAddu, 5'd3, 5'd1, 5'd2, 5'd0));
		emit(regOp(cpuPkg::fnSubu, 5'd4, 5'd3, 5'd1, 5'd0));
		emit(regOp(cpuPkg::fnAnd, 5'd5, 5'd3, 5'd2, 5'd0));
		emit(regOp(cpuPkg::fnOr, 5'd6, 5'd4, 5'd5, 5'd0));
		emit(regOp(cpuPkg::fnXor, 5'd7, 5'd6, 5'd1, 5'd0));
		emit(regOp(cpuPkg::fnNor, 5'd8, 5'd7, 5'd2, 5'd0));
		emit(regOp(cpuPkg::fnSlt, 5'd9, 5'd2, 5'd1, 5'd0));
		emit(regOp(cpuPkg::fnSlt, 5'd10, 5'd1, 5'd2, 5'd0));
		emit(regOp(cpuPkg::fnSll, 5'd11, 5'd0, 5'd1, 5'd4));
		emit(regOp(cpuPkg::fnSrl, 5'd12, 5'd0, 5'd2, 5'd8));
		emit(regOp(cpuPkg::fnSra, 5'd13, 5'd0, 5'd2, 5'd2));
		emit(immOp(cpuPkg::opSlti, 5'd14, 5'd2, 16'hFFFF));
		emit(immOp(cpuPkg::opAndi, 5'd15, 5'd2, 16'hFF0F));
		emit(immOp(cpuPkg::opOri, 5'd16, 5'd1, 16'h8000));
		emit(immOp(cpuPkg::opXori, 5'd17, 5'd2, 16'hFFFF));
		emit(immOp(cpuPkg::opLui, 5'd18, 5'd0, 16'hABCD));
		emit(regOp(cpuPkg::fnAddu, 5'd18, 5'd18, 5'd18, 5'd0));
		emit({cpuPkg::opHalt, 26'b0});
	endtask

	task automatic buildMemBranchProgram();
		progLen = 0;
		emit(immOp(cpuPkg::opAddiu, 5'd1, 5'd0, 16'd10));
		emit(immOp(cpuPkg::opAddiu, 5'd2, 5'd0, 16'h0055));
		emit(immOp(cpuPkg::opSw, 5'd2, 5'd1, 16'd3));
		emit(immOp(cpuPkg::opLw, 5'd3, 5'd1, 16'd3));
		// Load-use pair
		emit(regOp(cpuPkg::fnAddu, 5'd4, 5'd3, 5'd3, 5'd0));
		emit(immOp(cpuPkg::opSw, 5'd4, 5'd0, 16'd0));
		emit(immOp(cpuPkg::opLw, 5'd5, 5'd0, 16'd0));
		// Taken BEQ on a load result skips word 8
		emit(immOp(cpuPkg::opBeq, 5'd4, 5'd5, 16'd1));
		emit(immOp(cpuPkg::opAddiu, 5'd6, 5'd0, 16'd1));
		emit(immOp(cpuPkg::opAddiu, 5'd7, 5'd0, 16'd3));
		emit(immOp(cpuPkg::opAddiu, 5'd8, 5'd0, 16'd0));
		// Counting loop at word 11
		emit(immOp(cpuPkg::opAddiu, 5'd8, 5'd8, 16'd2));
		emit(immOp(cpuPkg::opAddiu, 5'd7, 5'd7, 16'hFFFF));
		emit(immOp(cpuPkg::opBne, 5'd0, 5'd7, 16'hFFFD));
		emit(immOp(cpuPkg::opBeq, 5'd1, 5'd7, 16'd5));
		emit(immOp(cpuPkg::opAddiu, 5'd9, 5'd0, 16'd7));
		emit({cpuPkg::opJ, 18'b0, 8'd18});
		emit(immOp(cpuPkg::opAddiu, 5'd10, 5'd0, 16'd9));
		emit(regOp(cpuPkg::fnAddu, 5'd11, 5'd9, 5'd8, 5'd0));
		emit({cpuPkg::opHalt, 26'b0});
	endtask

	task automatic buildRandomProgram();
		logic [31:0] r;
		logic [4:0] rd, rs, rt;
		progLen = 0;
		// Known start values for r1 to r7
		for (int i = 1; i < 8; i++) begin
			r = $random(seed);
			emit(immOp(cpuPkg::opAddiu, i[4:0], 5'd0, r[15:0]));
		end
		for (int i = 0; i < 40; i++) begin
			r = $random(seed);
			rd = {2'b0, r[6:4]};
			rs = {2'b0, r[9:7]};
			rt = {2'b0, r[12:10]};
			case (r[3:0])
				4'd0:  emit(regOp(cpuPkg::fnAddu, rd, rs, rt, 5'd0));
				4'd1:  emit(regOp(cpuPkg::fnSubu, rd, rs, rt, 5'd0));
				4'd2:  emit(regOp(cpuPkg::fnAnd, rd, rs, rt, 5'd0));
				4'd3:  emit(regOp(cpuPkg::fnOr, rd, rs, rt, 5'd0));
				4'd4:  emit(regOp(cpuPkg::fnXor, rd, rs, rt, 5'd0));
				4'd5:  emit(regOp(cpuPkg::fnNor, rd, rs, rt, 5'd0));
				4'd6:  emit(regOp(cpuPkg::fnSlt, rd, rs, rt, 5'd0));
				4'd7:  emit(regOp(cpuPkg::fnSll, rd, 5'd0, rt, r[17:13]));
				4'd8:  emit(regOp(cpuPkg::fnSrl, rd, 5'd0, rt, r[17:13]));
				4'd9:  emit(regOp(cpuPkg::fnSra, rd, 5'd0, rt, r[17:13]));
				4'd10: emit(immOp(cpuPkg::opAddiu, rd, rs, r[31:16]));
				4'd11: emit(immOp(cpuPkg::opSlti, rd, rs, r[31:16]));
				4'd12: emit(immOp(cpuPkg::opAndi, rd, rs, r[31:16]));
				4'd13: emit(immOp(cpuPkg::opOri, rd, rs, r[31:16]));
				4'd14: emit(immOp(cpuPkg::opXori, rd, rs, r[31:16]));
				default: emit(immOp(cpuPkg::opLui, rd, 5'd0, r[31:16]));
			endcase
		end
		emit({cpuPkg::opHalt, 26'b0});
	endtask

	initial begin
		arstN = 1'b0;
		run = 1'b0;
		imemWe = 1'b0;
		imemAddr = '0;
		imemData = '0;
		seed = 32'h24fa56db;
		buildAluProgram();
		runProgram("ALU program");
		buildMemBranchProgram();
		runProgram("memory and branch program");
		buildRandomProgram();
		runProgram("random program");
		$display("TEST PASS");
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+tests
logic/cpuPkg.sv
logic/stageReg.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/resultStage.sv
logic/hazardUnit.sv
logic/pipelineCore.sv
tests/coreTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= coreTb
BUILD_DIR ?= build
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory $(BUILD_DIR)"
	@echo "Variables (override on the command line):"
	@echo "  VERILATOR=$(VERILATOR) TOP=$(TOP) BUILD_DIR=$(BUILD_DIR)"
	@echo "  VFLAGS=$(VFLAGS)"

# The simulator exits nonzero on $$fatal, so make fails with the run
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f flist.f
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
